//--- src/apu_pkg.sv
`default_nettype none

package apu_pkg;

  //////////////////////////////////////////////////
  // Widths and counts
  //////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_AW     = 6;
  localparam int unsigned NUSFLAGS   = 2;
  localparam int unsigned DIV_CYCLES = 32;
  // Iteration counter width of the divider
  localparam int unsigned DIV_CNT_W  = $clog2(DIV_CYCLES);

  // Opcodes understood by the integer unit
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_MUL = 3'd2,
    OP_DIV = 3'd3,
    OP_REM = 3'd4
  } apu_op_e;

  // Latency classes, never mixed while in flight
  typedef enum logic [1:0] {
    LAT_COMB = 2'd0,
    LAT_PIPE = 2'd1,
    LAT_ITER = 2'd2
  } apu_lat_e;

  typedef struct packed {
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } apu_operands_t;

  // Dispatcher to unit
  typedef struct packed {
    logic          req;
    apu_op_e       op;
    apu_operands_t operands;
  } apu_req_t;

  typedef struct packed {
    logic zero;
    logic divzero;
  } apu_flags_t;

  // Unit to dispatcher, one-cycle pulse
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] result;
    apu_flags_t      flags;
  } apu_rsp_t;

  // Dispatcher to core register file
  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] waddr;
    logic [XLEN-1:0]   result;
    apu_flags_t        flags;
  } apu_wb_t;

  // Latency class of an opcode
  function automatic apu_lat_e op_lat_class(input apu_op_e op);
    case (op)
      OP_ADD, OP_SUB: return LAT_COMB;
      OP_MUL:         return LAT_PIPE;
      default:        return LAT_ITER;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- src/apu_mul_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module apu_mul_pipe (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   start_i,
  input  wire apu_pkg::apu_operands_t operands_i,
  output logic                        valid_o,
  output logic [apu_pkg::XLEN-1:0]    product_o
);

  // Stage one holds operands, stage two the product
  logic                     s1_valid_q, s2_valid_q;
  apu_pkg::apu_operands_t   s1_ops_q;
  logic [apu_pkg::XLEN-1:0] s2_prod_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= start_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Payload follows the valid bits
  always_ff @(posedge clk_i) begin
    s1_ops_q  <= operands_i;
    // Low word only
    s2_prod_q <= s1_ops_q.a * s1_ops_q.b;
  end

  assign valid_o   = s2_valid_q;
  assign product_o = s2_prod_q;

endmodule

`default_nettype wire

//--- src/apu_div_iter.sv
`timescale 1ns/100ps
`default_nettype none

module apu_div_iter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   start_i,
  input  wire logic                   rem_i,
  input  wire apu_pkg::apu_operands_t operands_i,
  output logic                        busy_o,
  output logic                        valid_o,
  output logic [apu_pkg::XLEN-1:0]    result_o,
  output logic                        divzero_o
);

  logic                          busy_q, done_q;
  logic [apu_pkg::DIV_CNT_W-1:0] cnt_q;
  logic [apu_pkg::XLEN-1:0]      quo_q, rem_q, dvs_q;
  logic                          rem_sel_q, divzero_q;
  // Shifted partial remainder, one bit wider than the divisor
  logic [apu_pkg::XLEN:0]        partial;
  logic                          fits;

  assign partial = {rem_q, quo_q[apu_pkg::XLEN-1]};
  assign fits    = (partial >= {1'b0, dvs_q});

  // Control
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Last iteration, result shows up next cycle
        if (cnt_q == apu_pkg::DIV_CNT_W'(apu_pkg::DIV_CYCLES - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Datapath, one quotient bit per cycle
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      quo_q     <= operands_i.a;
      rem_q     <= '0;
      dvs_q     <= operands_i.b;
      rem_sel_q <= rem_i;
      divzero_q <= (operands_i.b == '0);
    end else if (busy_q) begin
      // Restoring step, zero divisor always fits
      rem_q <= fits ? apu_pkg::XLEN'(partial - {1'b0, dvs_q}) : partial[apu_pkg::XLEN-1:0];
      quo_q <= {quo_q[apu_pkg::XLEN-2:0], fits};
    end
  end

  assign busy_o    = busy_q;
  assign valid_o   = done_q;
  assign result_o  = rem_sel_q ? rem_q : quo_q;
  assign divzero_o = divzero_q;

endmodule

`default_nettype wire

//--- src/apu_int_unit.sv
`timescale 1ns/100ps
`default_nettype none

module apu_int_unit (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire apu_pkg::apu_req_t req_i,
  output logic                   ack_o,
  output apu_pkg::apu_rsp_t      rsp_o
);

  apu_pkg::apu_lat_e          lat;
  logic                       accept;
  logic                       comb_valid;
  logic [apu_pkg::XLEN-1:0]   addsub_res;
  logic                       mul_valid;
  logic [apu_pkg::XLEN-1:0]   mul_res;
  logic                       div_busy, div_valid, div_divzero;
  logic [apu_pkg::XLEN-1:0]   div_res;

  assign lat    = apu_pkg::op_lat_class(req_i.op);
  // Divider holds off new requests while iterating
  assign ack_o  = ~div_busy;
  assign accept = req_i.req & ack_o;

  // ADD and SUB answer in the accept cycle
  assign comb_valid = accept & (lat == apu_pkg::LAT_COMB);
  assign addsub_res = (req_i.op == apu_pkg::OP_SUB) ?
                      req_i.operands.a - req_i.operands.b :
                      req_i.operands.a + req_i.operands.b;

  apu_mul_pipe i_mul (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (accept & (lat == apu_pkg::LAT_PIPE)),
    .operands_i (req_i.operands),
    .valid_o    (mul_valid),
    .product_o  (mul_res)
  );

  apu_div_iter i_div (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (accept & (lat == apu_pkg::LAT_ITER)),
    .rem_i      (req_i.op == apu_pkg::OP_REM),
    .operands_i (req_i.operands),
    .busy_o     (div_busy),
    .valid_o    (div_valid),
    .result_o   (div_res),
    .divzero_o  (div_divzero)
  );

  // At most one source returns per cycle
  always_comb begin
    if (comb_valid) begin
      rsp_o.result = addsub_res;
    end else if (mul_valid) begin
      rsp_o.result = mul_res;
    end else begin
      rsp_o.result = div_res;
    end
  end

  assign rsp_o.valid         = comb_valid | mul_valid | div_valid;
  assign rsp_o.flags.zero    = (rsp_o.result == '0);
  assign rsp_o.flags.divzero = div_valid & div_divzero;

endmodule

`default_nettype wire

//--- src/apu_dispatcher.sv
`timescale 1ns/100ps
`default_nettype none

module apu_dispatcher (
  input  wire logic                                       clk_i,
  input  wire logic                                       rst_ni,
  // Core issue side
  input  wire logic                                       enable_i,
  input  wire apu_pkg::apu_op_e                           op_i,
  input  wire apu_pkg::apu_operands_t                     operands_i,
  input  wire logic [apu_pkg::REG_AW-1:0]                 waddr_i,
  // Dependency check inputs
  input  wire logic [2:0][apu_pkg::REG_AW-1:0]            read_regs_i,
  input  wire logic [2:0]                                 read_regs_valid_i,
  input  wire logic [1:0][apu_pkg::REG_AW-1:0]            write_regs_i,
  input  wire logic [1:0]                                 write_regs_valid_i,
  // Unit side
  input  wire logic                                       ack_i,
  input  wire apu_pkg::apu_rsp_t                          rsp_i,
  output apu_pkg::apu_req_t                               req_o,
  // Core status side
  output apu_pkg::apu_wb_t                                wb_o,
  output logic                                            active_o,
  output logic                                            stall_o,
  output logic                                            read_dep_o,
  output logic                                            write_dep_o,
  output logic                                            perf_type_o,
  output logic                                            perf_cont_o
);

  // One outstanding destination
  typedef struct packed {
    logic                       valid;
    logic [apu_pkg::REG_AW-1:0] addr;
  } slot_t;

  slot_t             inflight_q, inflight_d;
  slot_t             waiting_q, waiting_d;
  apu_pkg::apu_lat_e lat_q;
  apu_pkg::apu_lat_e lat_new;

  logic valid_req, req_accepted;
  logic returned_req, returned_inflight, returned_waiting;
  logic stall_full, stall_type, stall_nack;
  logic active;

  // Live entries for the hazard check: request, inflight, waiting
  logic [2:0]                             live;
  logic [2:0][apu_pkg::REG_AW-1:0]        live_addr;

  //////////////////////////////////////////////////
  // Request generation
  //////////////////////////////////////////////////

  assign lat_new      = apu_pkg::op_lat_class(op_i);
  // Nack stall still requests, so the request repeats until acked
  assign valid_req    = enable_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & ack_i;

  assign req_o.req      = valid_req;
  assign req_o.op       = op_i;
  assign req_o.operands = operands_i;

  // Results arrive in order, oldest slot first
  assign returned_req      = valid_req & rsp_i.valid & ~inflight_q.valid & ~waiting_q.valid;
  assign returned_inflight = inflight_q.valid & rsp_i.valid & ~waiting_q.valid;
  assign returned_waiting  = waiting_q.valid & rsp_i.valid;

  //////////////////////////////////////////////////
  // Outstanding slots
  //////////////////////////////////////////////////

  always_comb begin
    inflight_d = inflight_q;
    waiting_d  = waiting_q;
    // Clear whichever slot returned
    if (returned_waiting) begin
      waiting_d.valid = 1'b0;
    end else if (returned_inflight) begin
      inflight_d.valid = 1'b0;
    end
    // Multicycle request takes the inflight slot
    if (req_accepted && !returned_req) begin
      inflight_d.valid = 1'b1;
      inflight_d.addr  = waddr_i;
      // Older live entry moves down to waiting
      if (inflight_q.valid && !returned_inflight) begin
        waiting_d = inflight_q;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
      waiting_q  <= '0;
      lat_q      <= apu_pkg::LAT_COMB;
    end else begin
      inflight_q <= inflight_d;
      waiting_q  <= waiting_d;
      // Class of the last accepted request
      if (req_accepted) begin
        lat_q <= lat_new;
      end
    end
  end

  assign active   = inflight_q.valid | waiting_q.valid;
  assign active_o = active;

  //////////////////////////////////////////////////
  // Hazards
  //////////////////////////////////////////////////

  assign live[0]      = valid_req & ~returned_req;
  assign live[1]      = inflight_q.valid & ~returned_inflight;
  assign live[2]      = waiting_q.valid & ~returned_waiting;
  assign live_addr[0] = waddr_i;
  assign live_addr[1] = inflight_q.addr;
  assign live_addr[2] = waiting_q.addr;

  always_comb begin
    read_dep_o  = 1'b0;
    write_dep_o = 1'b0;
    // Register zero is never a dependency
    for (int r = 0; r < 3; r++) begin
      for (int e = 0; e < 3; e++) begin
        if (read_regs_valid_i[r] && (read_regs_i[r] != '0) && live[e] &&
            (read_regs_i[r] == live_addr[e])) begin
          read_dep_o = 1'b1;
        end
      end
    end
    for (int w = 0; w < 2; w++) begin
      for (int e = 0; e < 3; e++) begin
        if (write_regs_valid_i[w] && (write_regs_i[w] != '0) && live[e] &&
            (write_regs_i[w] == live_addr[e])) begin
          write_dep_o = 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stalls and writeback
  //////////////////////////////////////////////////

  assign stall_full = inflight_q.valid & waiting_q.valid;
  // Only MUL may follow MUL while busy
  assign stall_type = active & ((lat_new != apu_pkg::LAT_PIPE) | (lat_q != apu_pkg::LAT_PIPE));
  assign stall_nack = valid_req & ~ack_i;
  assign stall_o    = stall_full | stall_type | stall_nack;

  assign perf_type_o = stall_type;
  assign perf_cont_o = stall_nack;

  assign wb_o.valid  = rsp_i.valid;
  assign wb_o.result = rsp_i.result;
  assign wb_o.flags  = rsp_i.flags;

  // Address of the returning instruction
  always_comb begin
    if (returned_req) begin
      wb_o.waddr = waddr_i;
    end else if (waiting_q.valid) begin
      wb_o.waddr = waiting_q.addr;
    end else begin
      wb_o.waddr = inflight_q.addr;
    end
  end

endmodule

`default_nettype wire

//--- src/apu_subsystem.sv
`timescale 1ns/100ps
`default_nettype none

module apu_subsystem (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            enable_i,
  input  wire apu_pkg::apu_op_e                op_i,
  input  wire apu_pkg::apu_operands_t          operands_i,
  input  wire logic [apu_pkg::REG_AW-1:0]      waddr_i,
  input  wire logic [2:0][apu_pkg::REG_AW-1:0] read_regs_i,
  input  wire logic [2:0]                      read_regs_valid_i,
  input  wire logic [1:0][apu_pkg::REG_AW-1:0] write_regs_i,
  input  wire logic [1:0]                      write_regs_valid_i,
  output apu_pkg::apu_wb_t                     wb_o,
  output logic                                 active_o,
  output logic                                 stall_o,
  output logic                                 read_dep_o,
  output logic                                 write_dep_o,
  output logic                                 perf_type_o,
  output logic                                 perf_cont_o
);

  // Dispatcher to unit link
  apu_pkg::apu_req_t unit_req;
  apu_pkg::apu_rsp_t unit_rsp;
  logic              unit_ack;

  apu_dispatcher i_disp (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .enable_i           (enable_i),
    .op_i               (op_i),
    .operands_i         (operands_i),
    .waddr_i            (waddr_i),
    .read_regs_i        (read_regs_i),
    .read_regs_valid_i  (read_regs_valid_i),
    .write_regs_i       (write_regs_i),
    .write_regs_valid_i (write_regs_valid_i),
    .ack_i              (unit_ack),
    .rsp_i              (unit_rsp),
    .req_o              (unit_req),
    .wb_o               (wb_o),
    .active_o           (active_o),
    .stall_o            (stall_o),
    .read_dep_o         (read_dep_o),
    .write_dep_o        (write_dep_o),
    .perf_type_o        (perf_type_o),
    .perf_cont_o        (perf_cont_o)
  );

  apu_int_unit i_unit (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (unit_req),
    .ack_o  (unit_ack),
    .rsp_o  (unit_rsp)
  );

endmodule

`default_nettype wire

//--- sim/apu_subsystem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module apu_subsystem_tb;

  localparam int ISSUE_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int NUM_RANDOM    = 200;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic                                 enable_i;
  apu_pkg::apu_op_e                     op_i;
  apu_pkg::apu_operands_t               operands_i;
  logic [apu_pkg::REG_AW-1:0]           waddr_i;
  logic [2:0][apu_pkg::REG_AW-1:0]      read_regs_i;
  logic [2:0]                           read_regs_valid_i;
  logic [1:0][apu_pkg::REG_AW-1:0]      write_regs_i;
  logic [1:0]                           write_regs_valid_i;
  apu_pkg::apu_wb_t                     wb_o;
  logic                                 active_o, stall_o, read_dep_o, write_dep_o;
  logic                                 perf_type_o, perf_cont_o;

  // Scoreboard in program order, with due cycle per accepted instruction
  apu_pkg::apu_wb_t exp_q[$];
  int               due_q[$];
  int               cycle = 0;
  integer           seed;
  string            test_name = "reset";

  apu_subsystem dut0 (.*);

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////

  function automatic apu_pkg::apu_wb_t ref_result(input apu_pkg::apu_op_e op,
                                                  input logic [apu_pkg::XLEN-1:0] a,
                                                  input logic [apu_pkg::XLEN-1:0] b);
    apu_pkg::apu_wb_t wb;
    wb       = '0;
    wb.valid = 1'b1;
    case (op)
      apu_pkg::OP_ADD: wb.result = a + b;
      apu_pkg::OP_SUB: wb.result = a - b;
      apu_pkg::OP_MUL: wb.result = a * b;
      // Divide by zero gives all ones, remainder keeps the dividend
      apu_pkg::OP_DIV: wb.result = (b == '0) ? '1 : a / b;
      default:         wb.result = (b == '0) ? a : a % b;
    endcase
    wb.flags.zero    = (wb.result == '0);
    wb.flags.divzero = (op == apu_pkg::OP_DIV || op == apu_pkg::OP_REM) && (b == '0);
    return wb;
  endfunction

  // Cycles from acceptance to writeback
  function automatic int ref_latency(input apu_pkg::apu_op_e op);
    case (op)
      apu_pkg::OP_ADD, apu_pkg::OP_SUB: return 0;
      apu_pkg::OP_MUL:                  return 2;
      default:                          return apu_pkg::DIV_CYCLES + 1;
    endcase
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_wb(input string name, input apu_pkg::apu_wb_t exp,
                          input apu_pkg::apu_wb_t act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected addr %0d res %h flags %b, actual %0d %h %b",
                               name, exp.waddr, exp.result, exp.flags,
                               act.waddr, act.result, act.flags));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_cycle(input string name, input int exp, input int act);
    if (act != exp) begin
      report_failure($sformatf("FAILED %s: expected cycle %0d, actual %0d", name, exp, act));
    end
  endtask

  // Compares each writeback with the oldest expected entry
  always @(negedge clk_i) begin
    apu_pkg::apu_wb_t exp_wb;
    int               due;
    cycle = cycle + 1;
    if (rst_ni) begin
      // Type stall keeps requests off a busy divider, so no nack
      check_bit({test_name, " perf_cont"}, 1'b0, perf_cont_o);
      if (enable_i && !stall_o) begin
        due_q.push_back(cycle + ref_latency(op_i));
      end
      if (wb_o.valid) begin
        if (exp_q.size() == 0 || due_q.size() == 0) begin
          report_failure("Writeback seen with no outstanding instruction");
        end else begin
          exp_wb = exp_q.pop_front();
          due    = due_q.pop_front();
          check_wb(test_name, exp_wb, wb_o);
          check_cycle({test_name, " latency"}, due, cycle);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Presents one instruction and holds it until it issues
  task automatic issue(input apu_pkg::apu_op_e op, input logic [apu_pkg::XLEN-1:0] a,
                       input logic [apu_pkg::XLEN-1:0] b,
                       input logic [apu_pkg::REG_AW-1:0] waddr,
                       output bit first_stall, output bit first_type);
    apu_pkg::apu_wb_t exp_wb;
    int               waited;
    @(posedge clk_i);
    enable_i     <= 1'b1;
    op_i         <= op;
    operands_i   <= {a, b};
    waddr_i      <= waddr;
    exp_wb       = ref_result(op, a, b);
    exp_wb.waddr = waddr;
    exp_q.push_back(exp_wb);
    waited       = 0;
    @(negedge clk_i);
    first_stall = stall_o;
    first_type  = perf_type_o;
    while (stall_o) begin
      waited++;
      if (waited > ISSUE_TIMEOUT) begin
        report_failure("Timeout waiting for an instruction to issue");
      end else begin
        @(negedge clk_i);
      end
    end
  endtask

  task automatic go_idle();
    @(posedge clk_i);
    enable_i <= 1'b0;
  endtask

  // Waits until every expected writeback has been seen
  task automatic drain();
    int waited;
    waited = 0;
    go_idle();
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        report_failure("Timeout waiting for outstanding results to return");
      end else begin
        @(posedge clk_i);
      end
    end
  endtask

  // Hazard model from the scoreboard's outstanding addresses
  function automatic bit outstanding(input logic [apu_pkg::REG_AW-1:0] addr, input logic valid);
    bit hit;
    hit = 1'b0;
    if (valid && addr != '0) begin
      foreach (exp_q[i]) begin
        if (exp_q[i].waddr == addr) begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  // Register zero, the outstanding one, or anything
  function automatic logic [apu_pkg::REG_AW-1:0] pick_reg();
    case ($unsigned($random(seed)) % 3)
      0:       return '0;
      1:       return 6'd9;
      default: return 6'($random(seed));
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    apu_pkg::apu_op_e            op;
    logic [apu_pkg::XLEN-1:0]    a, b;
    int                          gap;
    bit                          s, t, exp_rd, exp_wr;
    seed               = 32'he058;
    rst_ni             = 1'b0;
    enable_i           = 1'b0;
    op_i               = apu_pkg::OP_ADD;
    operands_i         = '0;
    waddr_i            = '0;
    read_regs_i        = '0;
    read_regs_valid_i  = '0;
    write_regs_i       = '0;
    write_regs_valid_i = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("reset stall", 1'b0, stall_o);
    check_bit("reset active", 1'b0, active_o);
    check_bit("reset wb valid", 1'b0, wb_o.valid);

    test_name = "add_sub";
    issue(apu_pkg::OP_ADD, 32'd7, 32'd9, 6'd3, s, t);
    issue(apu_pkg::OP_SUB, 32'd5, 32'd5, 6'd4, s, t);
    issue(apu_pkg::OP_SUB, 32'd1, 32'd2, 6'd5, s, t);
    drain();

    // Third MUL finds both slots taken
    test_name = "mul_pair";
    issue(apu_pkg::OP_MUL, 32'd1234, 32'd5678, 6'd10, s, t);
    issue(apu_pkg::OP_MUL, 32'hffff_ffff, 32'd3, 6'd11, s, t);
    issue(apu_pkg::OP_MUL, 32'd0, 32'd99, 6'd12, s, t);
    check_bit("third mul full stall", 1'b1, s);
    check_bit("third mul no type stall", 1'b0, t);
    drain();

    test_name = "div_rem";
    issue(apu_pkg::OP_DIV, 32'd100, 32'd7, 6'd13, s, t);
    issue(apu_pkg::OP_REM, 32'd100, 32'd7, 6'd14, s, t);
    issue(apu_pkg::OP_DIV, 32'h1234_5678, 32'd0, 6'd15, s, t);
    issue(apu_pkg::OP_REM, 32'h0bad_cafe, 32'd0, 6'd16, s, t);
    issue(apu_pkg::OP_DIV, 32'hffff_fff0, 32'd3, 6'd17, s, t);
    issue(apu_pkg::OP_MUL, 32'd6, 32'd7, 6'd18, s, t);
    check_bit("mul during div stall", 1'b1, s);
    check_bit("mul during div type", 1'b1, t);
    drain();

    test_name = "mul_then_add";
    issue(apu_pkg::OP_MUL, 32'd11, 32'd13, 6'd20, s, t);
    issue(apu_pkg::OP_ADD, 32'd1, 32'd1, 6'd21, s, t);
    check_bit("add after mul stall", 1'b1, s);
    check_bit("add after mul type", 1'b1, t);
    drain();

    // Sweep hazard inputs while a DIV to r9 is outstanding
    test_name = "hazards";
    issue(apu_pkg::OP_DIV, 32'd999, 32'd10, 6'd9, s, t);
    go_idle();
    for (int k = 0; k < 24; k++) begin
      @(posedge clk_i);
      for (int r = 0; r < 3; r++) begin
        read_regs_i[r] <= pick_reg();
      end
      for (int w = 0; w < 2; w++) begin
        write_regs_i[w] <= pick_reg();
      end
      read_regs_valid_i  <= 3'($random(seed));
      write_regs_valid_i <= 2'($random(seed));
      @(negedge clk_i);
      exp_rd = 1'b0;
      exp_wr = 1'b0;
      for (int r = 0; r < 3; r++) begin
        exp_rd |= outstanding(read_regs_i[r], read_regs_valid_i[r]);
      end
      for (int w = 0; w < 2; w++) begin
        exp_wr |= outstanding(write_regs_i[w], write_regs_valid_i[w]);
      end
      check_bit("read_dep", exp_rd, read_dep_o);
      check_bit("write_dep", exp_wr, write_dep_o);
    end
    @(posedge clk_i);
    read_regs_valid_i  <= '0;
    write_regs_valid_i <= '0;
    drain();

    test_name = "random";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      op = apu_pkg::apu_op_e'(3'($unsigned($random(seed)) % 5));
      a  = $random(seed);
      case ($unsigned($random(seed)) % 4)
        0:       b = '0;
        1:       b = $random(seed) & 32'hff;
        default: b = $random(seed);
      endcase
      issue(op, a, b, 6'($random(seed)), s, t);
      gap = $unsigned($random(seed)) % 4;
      if (gap != 0) begin
        go_idle();
        repeat (gap - 1) @(posedge clk_i);
      end
    end
    drain();
    @(negedge clk_i);
    check_bit("active after drain", 1'b0, active_o);

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- apu_subsystem.f
src/apu_pkg.sv
src/apu_mul_pipe.sv
src/apu_div_iter.sv
src/apu_int_unit.sv
src/apu_dispatcher.sv
src/apu_subsystem.sv
sim/apu_subsystem_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= apu_subsystem_tb
RTL_TOP    ?= apu_subsystem
FLIST      ?= apu_subsystem.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall
PASS_MSG   ?= All tests passed
RTL_SRCS   ?= src/apu_pkg.sv src/apu_mul_pipe.sv src/apu_div_iter.sv \
              src/apu_int_unit.sv src/apu_dispatcher.sv src/apu_subsystem.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
